// File: Makefile
TB_TOP = tb_rbe_tile_ctrl

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f files.f --top-module rbe_tile_ctrl

sim:
	verilator --binary --timing -f files.f --top-module $(TB_TOP)
	./obj_dir/V$(TB_TOP) | tee /dev/stderr | grep -qx "No errors"

clean:
	rm -rf obj_dir

// File: files.f
hw/rbe_cfg_pkg.sv
hw/rbe_ctrl_pkg.sv
hw/rbe_cfg_regs.sv
hw/rbe_tile_loop.sv
hw/rbe_main_fsm.sv
hw/rbe_addr_gen.sv
hw/rbe_offset_ctrl.sv
hw/rbe_tile_ctrl.sv
sim/tb_rbe_tile_ctrl.sv

// File: hw/rbe_addr_gen.sv
// registered request stage that builds address, length and stride of the selected stream
`timescale 1ns/1ps
`default_nettype none

module rbe_addr_gen (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      issue_i,
  input  wire rbe_ctrl_pkg::stream_sel_e sel_i,
  input  wire rbe_cfg_pkg::mem_addr_t    x_addr_i,
  input  wire rbe_cfg_pkg::mem_addr_t    w_addr_i,
  input  wire rbe_cfg_pkg::mem_addr_t    nq_addr_i,
  input  wire rbe_cfg_pkg::mem_addr_t    y_addr_i,
  input  wire logic                      fs3_i,
  input  wire rbe_cfg_pkg::qw_t          qw_i,
  input  wire rbe_cfg_pkg::tile_cnt_t    k_in_idx_i,
  input  wire rbe_cfg_pkg::tile_cnt_t    k_out_idx_i,
  input  wire rbe_cfg_pkg::tile_cnt_t    w_tile_idx_i,
  output logic                           req_start_o,
  output rbe_ctrl_pkg::stream_sel_e      req_sel_o,
  output rbe_cfg_pkg::mem_addr_t         req_addr_o,
  output rbe_ctrl_pkg::stream_len_t      req_len_o,
  output rbe_ctrl_pkg::stream_len_t      req_stride_o
);

  rbe_cfg_pkg::mem_addr_t    addr_d;
  rbe_ctrl_pkg::stream_len_t len_d;
  rbe_ctrl_pkg::stream_len_t stride_d;

  always_comb begin
    case (sel_i)
      rbe_ctrl_pkg::FEAT: begin
        addr_d   = x_addr_i + rbe_cfg_pkg::mem_addr_t'(k_in_idx_i) * rbe_ctrl_pkg::X_TILE_BYTES;
        len_d    = fs3_i ? rbe_ctrl_pkg::stream_len_t'(rbe_ctrl_pkg::FEAT_LEN_FS3)
                         : rbe_ctrl_pkg::stream_len_t'(rbe_ctrl_pkg::FEAT_LEN_FS1);
        stride_d = rbe_ctrl_pkg::stream_len_t'(rbe_ctrl_pkg::BLOCK_STRIDE);
      end
      rbe_ctrl_pkg::WEIGHT: begin
        addr_d = w_addr_i + rbe_cfg_pkg::mem_addr_t'(w_tile_idx_i) * rbe_ctrl_pkg::W_TILE_BYTES;
        // 3x3 streams all qw bit planes at once, plus two header words
        if (fs3_i) begin
          len_d    = rbe_ctrl_pkg::stream_len_t'(
              rbe_ctrl_pkg::stream_len_t'(qw_i) * rbe_ctrl_pkg::TP + 2);
          stride_d = rbe_ctrl_pkg::stream_len_t'(rbe_ctrl_pkg::W_STRIDE_FS3);
        end else begin
          len_d    = rbe_ctrl_pkg::stream_len_t'(rbe_ctrl_pkg::TP + 2);
          stride_d = rbe_ctrl_pkg::stream_len_t'({qw_i, 2'b00});
        end
      end
      rbe_ctrl_pkg::NORM: begin
        addr_d   = nq_addr_i + rbe_cfg_pkg::mem_addr_t'(k_out_idx_i) * rbe_ctrl_pkg::NQ_TILE_BYTES;
        len_d    = rbe_ctrl_pkg::stream_len_t'(rbe_ctrl_pkg::NORM_LEN);
        stride_d = rbe_ctrl_pkg::stream_len_t'(rbe_ctrl_pkg::NORM_STRIDE);
      end
      default: begin
        addr_d   = y_addr_i + rbe_cfg_pkg::mem_addr_t'(k_out_idx_i) * rbe_ctrl_pkg::Y_TILE_BYTES;
        len_d    = rbe_ctrl_pkg::stream_len_t'(rbe_ctrl_pkg::OUT_LEN);
        stride_d = rbe_ctrl_pkg::stream_len_t'(rbe_ctrl_pkg::BLOCK_STRIDE);
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_start_o <= 1'b0;
    end else begin
      req_start_o <= issue_i;
    end
  end

  // fields held until the next issue
  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      req_sel_o    <= sel_i;
      req_addr_o   <= addr_d;
      req_len_o    <= len_d;
      req_stride_o <= stride_d;
    end
  end

endmodule

`default_nettype wire

// File: hw/rbe_cfg_pkg.sv
// register map and bus-side field types shared by the config slave and the datapath
`default_nettype none

package rbe_cfg_pkg;

  ///////////////////////////////////////////////////
  // bus and field widths
  ///////////////////////////////////////////////////

  typedef logic [3:0]  wb_addr_t;
  typedef logic [31:0] wb_data_t;
  typedef logic [31:0] mem_addr_t;
  typedef logic [7:0]  tile_cnt_t;
  typedef logic [3:0]  qw_t;

  ///////////////////////////////////////////////////
  // register word indices
  ///////////////////////////////////////////////////

  localparam wb_addr_t REG_X_ADDR  = 4'd0;
  localparam wb_addr_t REG_W_ADDR  = 4'd1;
  localparam wb_addr_t REG_NQ_ADDR = 4'd2;
  localparam wb_addr_t REG_Y_ADDR  = 4'd3;
  // input tiles [7:0], output tiles [15:8]
  localparam wb_addr_t REG_TILES   = 4'd4;
  // 3x3 mode [0], qw [7:4]
  localparam wb_addr_t REG_MODE    = 4'd5;
  // write bit 0 starts a job, read bit 0 is busy
  localparam wb_addr_t REG_CTRL    = 4'd6;

endpackage

`default_nettype wire

// File: hw/rbe_cfg_regs.sv
// wishbone classic register slave holding the job configuration, raises the job start
`timescale 1ns/1ps
`default_nettype none

module rbe_cfg_regs (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  wb_cyc_i,
  input  wire logic                  wb_stb_i,
  input  wire logic                  wb_we_i,
  input  wire rbe_cfg_pkg::wb_addr_t wb_adr_i,
  input  wire rbe_cfg_pkg::wb_data_t wb_dat_i,
  input  wire logic                  busy_i,
  output logic                       wb_ack_o,
  output rbe_cfg_pkg::wb_data_t      wb_dat_o,
  output logic                       start_o,
  output rbe_cfg_pkg::mem_addr_t     x_addr_o,
  output rbe_cfg_pkg::mem_addr_t     w_addr_o,
  output rbe_cfg_pkg::mem_addr_t     nq_addr_o,
  output rbe_cfg_pkg::mem_addr_t     y_addr_o,
  output rbe_cfg_pkg::tile_cnt_t     n_k_in_o,
  output rbe_cfg_pkg::tile_cnt_t     n_k_out_o,
  output logic                       fs3_o,
  output rbe_cfg_pkg::qw_t           qw_o
);

  logic ack_q;
  logic wr_en;

  // single-cycle ack, one cycle after the strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= wb_cyc_i & wb_stb_i & ~ack_q;
    end
  end

  assign wb_ack_o = ack_q;

  // writes land at the end of the ack cycle
  assign wr_en   = ack_q & wb_cyc_i & wb_stb_i & wb_we_i;
  assign start_o = wr_en & (wb_adr_i == rbe_cfg_pkg::REG_CTRL) & wb_dat_i[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      x_addr_o  <= '0;
      w_addr_o  <= '0;
      nq_addr_o <= '0;
      y_addr_o  <= '0;
      n_k_in_o  <= '0;
      n_k_out_o <= '0;
      fs3_o     <= 1'b0;
      qw_o      <= '0;
    end else if (wr_en) begin
      case (wb_adr_i)
        rbe_cfg_pkg::REG_X_ADDR:  x_addr_o  <= wb_dat_i;
        rbe_cfg_pkg::REG_W_ADDR:  w_addr_o  <= wb_dat_i;
        rbe_cfg_pkg::REG_NQ_ADDR: nq_addr_o <= wb_dat_i;
        rbe_cfg_pkg::REG_Y_ADDR:  y_addr_o  <= wb_dat_i;
        rbe_cfg_pkg::REG_TILES: begin
          n_k_in_o  <= wb_dat_i[7:0];
          n_k_out_o <= wb_dat_i[15:8];
        end
        rbe_cfg_pkg::REG_MODE: begin
          fs3_o <= wb_dat_i[0];
          qw_o  <= wb_dat_i[7:4];
        end
        default: ;
      endcase
    end
  end

  // read mux, sampled by the master while ack is high
  always_comb begin
    case (wb_adr_i)
      rbe_cfg_pkg::REG_X_ADDR:  wb_dat_o = x_addr_o;
      rbe_cfg_pkg::REG_W_ADDR:  wb_dat_o = w_addr_o;
      rbe_cfg_pkg::REG_NQ_ADDR: wb_dat_o = nq_addr_o;
      rbe_cfg_pkg::REG_Y_ADDR:  wb_dat_o = y_addr_o;
      rbe_cfg_pkg::REG_TILES:   wb_dat_o = {16'h0000, n_k_out_o, n_k_in_o};
      rbe_cfg_pkg::REG_MODE:    wb_dat_o = {24'h000000, qw_o, 3'b000, fs3_o};
      rbe_cfg_pkg::REG_CTRL:    wb_dat_o = {31'h0, busy_i};
      default:                  wb_dat_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/rbe_ctrl_pkg.sv
// sequencer states, stream ids and stream geometry used by the tile controller
`default_nettype none

package rbe_ctrl_pkg;

  typedef enum logic [3:0] {
    IDLE,
    FEAT_REQ,
    FEAT_WAIT,
    WEIGHT_REQ,
    WEIGHT_WAIT,
    NORM_REQ,
    NORM_WAIT,
    OUT_REQ,
    OUT_WAIT,
    UPDATE_IDX,
    TERMINATE
  } ctrl_state_e;

  typedef enum logic [1:0] {
    FEAT,
    WEIGHT,
    NORM,
    OUT
  } stream_sel_e;

  typedef logic [15:0] stream_len_t;

  ///////////////////////////////////////////////////
  // stream geometry
  ///////////////////////////////////////////////////

  localparam int unsigned TP            = 32;
  localparam int unsigned FEAT_LEN_FS1  = 9;
  localparam int unsigned FEAT_LEN_FS3  = 25;
  localparam int unsigned OUT_LEN       = 9;
  localparam int unsigned NORM_LEN      = 8;
  localparam int unsigned BLOCK_STRIDE  = 32;
  localparam int unsigned NORM_STRIDE   = 24;
  localparam int unsigned W_STRIDE_FS3  = 36;

  // per-tile footprint in memory, bytes
  localparam int unsigned X_TILE_BYTES  = 256;
  localparam int unsigned W_TILE_BYTES  = 1152;
  localparam int unsigned NQ_TILE_BYTES = 64;
  localparam int unsigned Y_TILE_BYTES  = 256;

  // pipeline depth from offset control to the accumulators
  localparam int unsigned OFFSET_DELAY  = 3;

endpackage

`default_nettype wire

// File: hw/rbe_main_fsm.sv
// job sequencer, orders the stream requests per tile and steps the tile loop
`timescale 1ns/1ps
`default_nettype none

module rbe_main_fsm (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               start_i,
  input  wire logic               stream_ready_i,
  input  wire logic               stream_done_i,
  input  wire logic               last_k_in_i,
  input  wire logic               last_tile_i,
  output logic                    busy_o,
  output logic                    issue_o,
  output rbe_ctrl_pkg::stream_sel_e sel_o,
  output logic                    loop_clear_o,
  output logic                    loop_step_o,
  output logic                    weight_phase_o,
  output logic                    done_o
);

  rbe_ctrl_pkg::ctrl_state_e state_q, state_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= rbe_ctrl_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////
  // next state and request control
  //////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    issue_o      = 1'b0;
    sel_o        = rbe_ctrl_pkg::FEAT;
    loop_clear_o = 1'b0;
    loop_step_o  = 1'b0;
    done_o       = 1'b0;

    case (state_q)
      rbe_ctrl_pkg::IDLE: begin
        if (start_i) begin
          loop_clear_o = 1'b1;
          state_d      = rbe_ctrl_pkg::FEAT_REQ;
        end
      end

      // request states hold while the streamer is not ready
      rbe_ctrl_pkg::FEAT_REQ: begin
        issue_o = stream_ready_i;
        if (stream_ready_i) state_d = rbe_ctrl_pkg::FEAT_WAIT;
      end
      rbe_ctrl_pkg::WEIGHT_REQ: begin
        sel_o   = rbe_ctrl_pkg::WEIGHT;
        issue_o = stream_ready_i;
        if (stream_ready_i) state_d = rbe_ctrl_pkg::WEIGHT_WAIT;
      end
      rbe_ctrl_pkg::NORM_REQ: begin
        sel_o   = rbe_ctrl_pkg::NORM;
        issue_o = stream_ready_i;
        if (stream_ready_i) state_d = rbe_ctrl_pkg::NORM_WAIT;
      end
      rbe_ctrl_pkg::OUT_REQ: begin
        sel_o   = rbe_ctrl_pkg::OUT;
        issue_o = stream_ready_i;
        if (stream_ready_i) state_d = rbe_ctrl_pkg::OUT_WAIT;
      end

      rbe_ctrl_pkg::FEAT_WAIT: begin
        if (stream_done_i) state_d = rbe_ctrl_pkg::WEIGHT_REQ;
      end
      rbe_ctrl_pkg::WEIGHT_WAIT: begin
        // normquant and store only after the last input tile
        if (stream_done_i) begin
          state_d = last_k_in_i ? rbe_ctrl_pkg::NORM_REQ : rbe_ctrl_pkg::UPDATE_IDX;
        end
      end
      rbe_ctrl_pkg::NORM_WAIT: begin
        if (stream_done_i) state_d = rbe_ctrl_pkg::OUT_REQ;
      end
      rbe_ctrl_pkg::OUT_WAIT: begin
        if (stream_done_i) state_d = rbe_ctrl_pkg::UPDATE_IDX;
      end

      rbe_ctrl_pkg::UPDATE_IDX: begin
        if (last_tile_i) begin
          state_d = rbe_ctrl_pkg::TERMINATE;
        end else begin
          loop_step_o = 1'b1;
          state_d     = rbe_ctrl_pkg::FEAT_REQ;
        end
      end

      rbe_ctrl_pkg::TERMINATE: begin
        done_o  = 1'b1;
        state_d = rbe_ctrl_pkg::IDLE;
      end

      default: state_d = rbe_ctrl_pkg::IDLE;
    endcase
  end

  // start is only looked at in IDLE, so a start mid-job is dropped
  assign busy_o         = (state_q != rbe_ctrl_pkg::IDLE);
  assign weight_phase_o = (state_q == rbe_ctrl_pkg::WEIGHT_WAIT);

endmodule

`default_nettype wire

// File: hw/rbe_offset_ctrl.sv
// accumulator offset control, enables on the first two weight handshakes, delayed 3 cycles
`timescale 1ns/1ps
`default_nettype none

module rbe_offset_ctrl (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic weight_phase_i,
  input  wire logic weight_valid_i,
  output logic      aq_offset_en_o,
  output logic      aq_offset_state_o
);

  logic [1:0] ws_cnt_q;
  logic       offset_en;
  logic       offset_state_q;
  logic [rbe_ctrl_pkg::OFFSET_DELAY-1:0] en_dly_q;
  logic [rbe_ctrl_pkg::OFFSET_DELAY-1:0] state_dly_q;

  assign offset_en = weight_phase_i & weight_valid_i & (ws_cnt_q < 2'd2);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ws_cnt_q       <= '0;
      offset_state_q <= 1'b0;
      en_dly_q       <= '0;
      state_dly_q    <= '0;
    end else begin
      // saturating, so no re-enable on long weight streams
      if (!weight_phase_i) begin
        ws_cnt_q <= '0;
      end else if (weight_valid_i && ws_cnt_q != 2'd3) begin
        ws_cnt_q <= ws_cnt_q + 2'd1;
      end
      if (offset_en) begin
        offset_state_q <= ~offset_state_q;
      end
      // align with the accumulator pipeline
      en_dly_q    <= {en_dly_q[rbe_ctrl_pkg::OFFSET_DELAY-2:0], offset_en};
      state_dly_q <= {state_dly_q[rbe_ctrl_pkg::OFFSET_DELAY-2:0], offset_state_q};
    end
  end

  assign aq_offset_en_o    = en_dly_q[rbe_ctrl_pkg::OFFSET_DELAY-1];
  assign aq_offset_state_o = state_dly_q[rbe_ctrl_pkg::OFFSET_DELAY-1];

endmodule

`default_nettype wire

// File: hw/rbe_tile_ctrl.sv
// top of the tile sequencer, connects config slave, FSM, tile loop, request stage and offsets
`timescale 1ns/1ps
`default_nettype none

module rbe_tile_ctrl (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  wb_cyc_i,
  input  wire logic                  wb_stb_i,
  input  wire logic                  wb_we_i,
  input  wire rbe_cfg_pkg::wb_addr_t wb_adr_i,
  input  wire rbe_cfg_pkg::wb_data_t wb_dat_i,
  output logic                       wb_ack_o,
  output rbe_cfg_pkg::wb_data_t      wb_dat_o,
  input  wire logic                  stream_ready_i,
  input  wire logic                  stream_done_i,
  input  wire logic                  weight_valid_i,
  output logic                       req_start_o,
  output rbe_ctrl_pkg::stream_sel_e  req_sel_o,
  output rbe_cfg_pkg::mem_addr_t     req_addr_o,
  output rbe_ctrl_pkg::stream_len_t  req_len_o,
  output rbe_ctrl_pkg::stream_len_t  req_stride_o,
  output logic                       done_o,
  output logic                       aq_offset_en_o,
  output logic                       aq_offset_state_o
);

  //////////////////////////////////////////////////
  // internal wiring
  //////////////////////////////////////////////////

  logic                      start, busy, issue, loop_clear, loop_step;
  logic                      weight_phase, last_k_in, last_tile, fs3;
  rbe_ctrl_pkg::stream_sel_e sel;
  rbe_cfg_pkg::mem_addr_t    x_addr, w_addr, nq_addr, y_addr;
  rbe_cfg_pkg::tile_cnt_t    n_k_in, n_k_out, k_in_idx, k_out_idx, w_tile_idx;
  rbe_cfg_pkg::qw_t          qw;

  rbe_cfg_regs i_cfg_regs (
    .clk_i, .rst_ni, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
    .busy_i    (busy),
    .wb_ack_o, .wb_dat_o,
    .start_o   (start),
    .x_addr_o  (x_addr),
    .w_addr_o  (w_addr),
    .nq_addr_o (nq_addr),
    .y_addr_o  (y_addr),
    .n_k_in_o  (n_k_in),
    .n_k_out_o (n_k_out),
    .fs3_o     (fs3),
    .qw_o      (qw)
  );

  rbe_main_fsm i_main_fsm (
    .clk_i, .rst_ni,
    .start_i        (start),
    .stream_ready_i, .stream_done_i,
    .last_k_in_i    (last_k_in),
    .last_tile_i    (last_tile),
    .busy_o         (busy),
    .issue_o        (issue),
    .sel_o          (sel),
    .loop_clear_o   (loop_clear),
    .loop_step_o    (loop_step),
    .weight_phase_o (weight_phase),
    .done_o
  );

  rbe_tile_loop i_tile_loop (
    .clk_i, .rst_ni,
    .loop_clear_i (loop_clear),
    .loop_step_i  (loop_step),
    .n_k_in_i     (n_k_in),
    .n_k_out_i    (n_k_out),
    .k_in_idx_o   (k_in_idx),
    .k_out_idx_o  (k_out_idx),
    .w_tile_idx_o (w_tile_idx),
    .last_k_in_o  (last_k_in),
    .last_tile_o  (last_tile)
  );

  rbe_addr_gen i_addr_gen (
    .clk_i, .rst_ni,
    .issue_i      (issue),
    .sel_i        (sel),
    .x_addr_i     (x_addr),
    .w_addr_i     (w_addr),
    .nq_addr_i    (nq_addr),
    .y_addr_i     (y_addr),
    .fs3_i        (fs3),
    .qw_i         (qw),
    .k_in_idx_i   (k_in_idx),
    .k_out_idx_i  (k_out_idx),
    .w_tile_idx_i (w_tile_idx),
    .req_start_o, .req_sel_o, .req_addr_o, .req_len_o, .req_stride_o
  );

  rbe_offset_ctrl i_offset_ctrl (
    .clk_i, .rst_ni,
    .weight_phase_i (weight_phase),
    .weight_valid_i,
    .aq_offset_en_o, .aq_offset_state_o
  );

endmodule

`default_nettype wire

// File: hw/rbe_tile_loop.sv
// two-level tile counter, input tiles inner and output tiles outer, stepped by the FSM
`timescale 1ns/1ps
`default_nettype none

module rbe_tile_loop (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   loop_clear_i,
  input  wire logic                   loop_step_i,
  input  wire rbe_cfg_pkg::tile_cnt_t n_k_in_i,
  input  wire rbe_cfg_pkg::tile_cnt_t n_k_out_i,
  output rbe_cfg_pkg::tile_cnt_t      k_in_idx_o,
  output rbe_cfg_pkg::tile_cnt_t      k_out_idx_o,
  output rbe_cfg_pkg::tile_cnt_t      w_tile_idx_o,
  output logic                        last_k_in_o,
  output logic                        last_tile_o
);

  logic last_k_out;

  // counts of zero are not supported
  assign last_k_in_o = (k_in_idx_o == rbe_cfg_pkg::tile_cnt_t'(n_k_in_i - 8'd1));
  assign last_k_out  = (k_out_idx_o == rbe_cfg_pkg::tile_cnt_t'(n_k_out_i - 8'd1));
  assign last_tile_o = last_k_in_o & last_k_out;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      k_in_idx_o   <= '0;
      k_out_idx_o  <= '0;
      w_tile_idx_o <= '0;
    end else if (loop_clear_i) begin
      k_in_idx_o   <= '0;
      k_out_idx_o  <= '0;
      w_tile_idx_o <= '0;
    end else if (loop_step_i) begin
      // weights are laid out linearly, one tile per step
      w_tile_idx_o <= w_tile_idx_o + 8'd1;
      if (last_k_in_o) begin
        k_in_idx_o  <= '0;
        k_out_idx_o <= k_out_idx_o + 8'd1;
      end else begin
        k_in_idx_o  <= k_in_idx_o + 8'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_rbe_tile_ctrl.sv
// testbench for the tile sequencer that runs a table of jobs over wishbone against a streamer model
`timescale 1ns/1ps
`default_nettype none

module tb_rbe_tile_ctrl;

  localparam int NJOBS    = 5;
  localparam int MAX_WAIT = 8;

  typedef struct {
    string       name;
    logic [31:0] x_base;
    logic [31:0] w_base;
    logic [31:0] nq_base;
    logic [31:0] y_base;
    int          n_in;
    int          n_out;
    bit          fs3;
    int          qw;
    bit          rand_ready;
    bit          mid_start;
  } job_t;

  logic        clk_i, rst_ni;
  logic        wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
  logic [3:0]  wb_adr_i;
  logic [31:0] wb_dat_i, wb_dat_o;
  logic        stream_ready_i, stream_done_i, weight_valid_i;
  logic        req_start_o, done_o, aq_offset_en_o, aq_offset_state_o;
  logic [1:0]  req_sel_o;
  logic [31:0] req_addr_o;
  logic [15:0] req_len_o, req_stride_o;

  job_t        jobs [NJOBS];
  logic [65:0] exp_q [$];
  logic [65:0] got_q [$];
  bit          en_exp [int];
  bit          st_exp [int];
  int          cyc_cnt = 0;
  int          cycle_limit = 100000;
  int          errors = 0;
  int          mon_errors = 0;
  int          done_cnt = 0;
  bit          rand_ready_en = 1'b0;
  bit          ready_prev = 1'b1;
  string       cur_test = "reset_regs";

  rbe_tile_ctrl i_rbe_tile_ctrl (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc_cnt <= cyc_cnt + 1;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [65:0] req_word(input logic [1:0] sel, input logic [31:0] addr,
                                           input int len, input int stride);
    return {sel, addr, len[15:0], stride[15:0]};
  endfunction

  ///////////////////////////////////////////////////
  // wishbone master
  ///////////////////////////////////////////////////

  task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int waits;
    @(posedge clk_i);
    #1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdata;
    waits    = 0;
    @(negedge clk_i);
    while (wb_ack_o !== 1'b1 && waits < 8) begin
      waits++;
      @(negedge clk_i);
    end
    if (waits != 1) begin
      $display("ERROR %s: ack latency expected 1 actual %0d", cur_test, waits);
      errors++;
    end
    rdata = wb_dat_o;
    @(posedge clk_i);
    #1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic bus_write(input logic [3:0] adr, input logic [31:0] wdata);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, wdata, unused);
  endtask

  task automatic bus_read_check(input logic [3:0] adr, input logic [31:0] expected);
    logic [31:0] rd;
    bus_cycle(1'b0, adr, 32'h0, rd);
    if (rd !== expected) begin
      $display("ERROR %s: reg %0d expected %h actual %h", cur_test, adr, expected, rd);
      errors++;
    end
  endtask

  ///////////////////////////////////////////////////
  // streamer model and weight handshakes
  ///////////////////////////////////////////////////

  initial begin : ready_driver
    logic [31:0] seed;
    seed = 32'h60ae;
    stream_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      #1;
      seed = lcg_next(seed);
      stream_ready_i = rand_ready_en ? (seed[23:22] != 2'b00) : 1'b1;
    end
  end

  initial begin : streamer
    int          wait_cycles;
    int          pulses;
    bit          is_weight;
    bit          parity;
    logic [31:0] seed;
    seed           = 32'h60ae;
    parity         = 1'b0;
    stream_done_i  = 1'b0;
    weight_valid_i = 1'b0;
    forever begin
      @(negedge clk_i);
      if (req_start_o === 1'b1) begin
        got_q.push_back({req_sel_o, req_addr_o, req_len_o, req_stride_o});
        is_weight   = (req_sel_o == rbe_ctrl_pkg::WEIGHT);
        seed        = lcg_next(seed);
        wait_cycles = 2 + int'(seed[20:16]) % (MAX_WAIT - 1);
        pulses      = 0;
        repeat (wait_cycles) begin
          @(posedge clk_i);
          #1;
          seed           = lcg_next(seed);
          // valid also pulses in the other phases, where no offset may follow
          weight_valid_i = seed[17];
          if (weight_valid_i && is_weight) begin
            // only the first two handshakes of a weight phase raise the offset
            if (pulses < 2) begin
              en_exp[cyc_cnt + rbe_ctrl_pkg::OFFSET_DELAY] = 1'b1;
              st_exp[cyc_cnt + rbe_ctrl_pkg::OFFSET_DELAY] = parity;
              parity = ~parity;
            end
            pulses++;
          end
        end
        @(posedge clk_i);
        #1;
        weight_valid_i = 1'b0;
        stream_done_i  = 1'b1;
        @(posedge clk_i);
        #1;
        stream_done_i = 1'b0;
      end
    end
  end

  // done pulses, back-pressure and offset outputs
  always @(negedge clk_i) begin : monitor
    bit exp_en;
    if (rst_ni) begin
      if (done_o === 1'b1) done_cnt++;
      if (req_start_o === 1'b1 && !ready_prev) begin
        $display("ERROR %s: request started after stream ready was low", cur_test);
        mon_errors++;
      end
      exp_en = en_exp.exists(cyc_cnt) ? 1'b1 : 1'b0;
      if (aq_offset_en_o !== exp_en) begin
        $display("ERROR %s: offset enable expected %b actual %b", cur_test, exp_en,
                 aq_offset_en_o);
        mon_errors++;
      end
      if (exp_en && aq_offset_state_o !== st_exp[cyc_cnt]) begin
        $display("ERROR %s: offset state expected %b actual %b", cur_test,
                 st_exp[cyc_cnt], aq_offset_state_o);
        mon_errors++;
      end
    end
    ready_prev = stream_ready_i;
  end

  always @(posedge clk_i) begin
    if (cyc_cnt > cycle_limit) begin
      $display("timeout after %0d cycles, the job did not finish", cyc_cnt);
      $display("Errors found");
      $finish;
    end
  end

  ///////////////////////////////////////////////////
  // jobs
  ///////////////////////////////////////////////////

  task automatic build_expected(input job_t jb);
    int w_idx;
    exp_q.delete();
    w_idx = 0;
    for (int ko = 0; ko < jb.n_out; ko++) begin
      for (int ki = 0; ki < jb.n_in; ki++) begin
        exp_q.push_back(req_word(rbe_ctrl_pkg::FEAT,
            jb.x_base + ki * rbe_ctrl_pkg::X_TILE_BYTES,
            jb.fs3 ? rbe_ctrl_pkg::FEAT_LEN_FS3 : rbe_ctrl_pkg::FEAT_LEN_FS1,
            rbe_ctrl_pkg::BLOCK_STRIDE));
        exp_q.push_back(req_word(rbe_ctrl_pkg::WEIGHT,
            jb.w_base + w_idx * rbe_ctrl_pkg::W_TILE_BYTES,
            jb.fs3 ? jb.qw * rbe_ctrl_pkg::TP + 2 : rbe_ctrl_pkg::TP + 2,
            jb.fs3 ? rbe_ctrl_pkg::W_STRIDE_FS3 : jb.qw * 4));
        w_idx++;
        if (ki == jb.n_in - 1) begin
          exp_q.push_back(req_word(rbe_ctrl_pkg::NORM,
              jb.nq_base + ko * rbe_ctrl_pkg::NQ_TILE_BYTES,
              rbe_ctrl_pkg::NORM_LEN, rbe_ctrl_pkg::NORM_STRIDE));
          exp_q.push_back(req_word(rbe_ctrl_pkg::OUT,
              jb.y_base + ko * rbe_ctrl_pkg::Y_TILE_BYTES,
              rbe_ctrl_pkg::OUT_LEN, rbe_ctrl_pkg::BLOCK_STRIDE));
        end
      end
    end
  endtask

  task automatic run_job(input job_t jb);
    int got_base;
    int done0;
    build_expected(jb);
    cur_test = jb.name;
    bus_write(rbe_cfg_pkg::REG_X_ADDR, jb.x_base);
    bus_write(rbe_cfg_pkg::REG_W_ADDR, jb.w_base);
    bus_write(rbe_cfg_pkg::REG_NQ_ADDR, jb.nq_base);
    bus_write(rbe_cfg_pkg::REG_Y_ADDR, jb.y_base);
    bus_write(rbe_cfg_pkg::REG_TILES, {16'h0, 8'(jb.n_out), 8'(jb.n_in)});
    bus_write(rbe_cfg_pkg::REG_MODE, {24'h0, 4'(jb.qw), 3'b000, jb.fs3});
    rand_ready_en = jb.rand_ready;
    got_base = got_q.size();
    done0    = done_cnt;
    bus_write(rbe_cfg_pkg::REG_CTRL, 32'h1);
    bus_read_check(rbe_cfg_pkg::REG_CTRL, 32'h1);
    // a second start while busy
    if (jb.mid_start) bus_write(rbe_cfg_pkg::REG_CTRL, 32'h1);
    while (done_cnt == done0) @(negedge clk_i);
    bus_read_check(rbe_cfg_pkg::REG_CTRL, 32'h0);
    repeat (20) @(negedge clk_i);
    rand_ready_en = 1'b0;
    if (done_cnt - done0 != 1) begin
      $display("ERROR %s: done pulses expected 1 actual %0d", cur_test, done_cnt - done0);
      errors++;
    end
    if (got_q.size() - got_base != exp_q.size()) begin
      $display("ERROR %s: request count expected %0d actual %0d", cur_test, exp_q.size(),
               got_q.size() - got_base);
      errors++;
    end
    for (int i = 0; i < exp_q.size() && got_base + i < got_q.size(); i++) begin
      if (got_q[got_base + i] !== exp_q[i]) begin
        $display("ERROR %s: request %0d expected %h actual %h", cur_test, i, exp_q[i],
                 got_q[got_base + i]);
        errors++;
      end
    end
  endtask

  initial begin : main
    int total_reqs;
    int err0;
    int failed;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    rst_ni   = 1'b0;
    failed   = 0;
    jobs[0] = '{"job_1x1", 32'h1000_0000, 32'h2000_0000, 32'h3000_0000, 32'h4000_0000,
                3, 2, 1'b0, 2, 1'b0, 1'b0};
    jobs[1] = '{"job_3x3", 32'h1100_0040, 32'h2200_0000, 32'h3300_0100, 32'h4400_0080,
                2, 2, 1'b1, 4, 1'b0, 1'b0};
    jobs[2] = '{"job_backpressure", 32'h0000_8000, 32'h0001_0000, 32'h0002_0000,
                32'h0003_0000, 2, 3, 1'b0, 8, 1'b1, 1'b0};
    jobs[3] = '{"job_mid_start", 32'h5000_0000, 32'h6000_0000, 32'h7000_0000, 32'h8000_0000,
                4, 1, 1'b1, 3, 1'b1, 1'b1};
    jobs[4] = '{"job_single_tile", 32'h0000_0100, 32'h0000_0200, 32'h0000_0300,
                32'h0000_0400, 1, 1, 1'b0, 1, 1'b0, 1'b0};
    total_reqs = 0;
    for (int j = 0; j < NJOBS; j++) total_reqs += jobs[j].n_out * (2 * jobs[j].n_in + 2);
    cycle_limit = 400 + total_reqs * 4 * MAX_WAIT;

    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // register readback and reset state
    @(negedge clk_i);
    if ({req_start_o, done_o, aq_offset_en_o} !== 3'b000) begin
      $display("ERROR %s: outputs expected 000 actual %b%b%b", cur_test, req_start_o, done_o,
               aq_offset_en_o);
      errors++;
    end
    bus_write(rbe_cfg_pkg::REG_X_ADDR, 32'h1357_9bd0);
    bus_read_check(rbe_cfg_pkg::REG_X_ADDR, 32'h1357_9bd0);
    bus_write(rbe_cfg_pkg::REG_W_ADDR, 32'h2468_ace0);
    bus_read_check(rbe_cfg_pkg::REG_W_ADDR, 32'h2468_ace0);
    bus_write(rbe_cfg_pkg::REG_NQ_ADDR, 32'h0bad_f00c);
    bus_read_check(rbe_cfg_pkg::REG_NQ_ADDR, 32'h0bad_f00c);
    bus_write(rbe_cfg_pkg::REG_Y_ADDR, 32'hfeed_0040);
    bus_read_check(rbe_cfg_pkg::REG_Y_ADDR, 32'hfeed_0040);
    bus_write(rbe_cfg_pkg::REG_TILES, 32'h0000_0302);
    bus_read_check(rbe_cfg_pkg::REG_TILES, 32'h0000_0302);
    bus_write(rbe_cfg_pkg::REG_MODE, 32'h0000_0051);
    bus_read_check(rbe_cfg_pkg::REG_MODE, 32'h0000_0051);
    bus_read_check(rbe_cfg_pkg::REG_CTRL, 32'h0);
    bus_read_check(4'hf, 32'h0);
    $display("%-18s %0d errors", cur_test, errors + mon_errors);
    if (errors + mon_errors != 0) failed++;

    for (int j = 0; j < NJOBS; j++) begin
      err0 = errors + mon_errors;
      run_job(jobs[j]);
      $display("%-18s %0d requests, %0d errors", jobs[j].name, exp_q.size(),
               errors + mon_errors - err0);
      if (errors + mon_errors != err0) failed++;
    end

    $display("tests %0d, failed %0d, errors %0d", NJOBS + 1, failed, errors + mon_errors);
    if (errors + mon_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
